// File: src/vmemPkg.sv
package vmemPkg;

   // every RAM is 256 words deep
   localparam int memAddrW = 8;

   // period, duty and delay fields
   localparam int periodW = 5;

   // flow bus words, MSB first: unit0 A, unit0 B, unit1 A, unit1 B
   localparam int nSrc = 4;
   localparam int selW = 2;

   typedef enum logic [1:0] {
      agIdle,
      agDelay,
      agRun,
      agDone
   } agStateT;

   // one port's program
   typedef struct packed {
      logic [memAddrW-1:0] iterations;
      logic [periodW-1:0]  period;
      logic [periodW-1:0]  duty;
      logic [periodW-1:0]  delay;
      logic [selW-1:0]     sel;
      logic [memAddrW-1:0] start;
      logic [memAddrW-1:0] shift;
      logic [memAddrW-1:0] incr;
      logic                reverse;
      logic                writeEn;
      logic                addrOutEn;
   } portCfgT;

   function automatic logic [memAddrW-1:0] reverseBits(input logic [memAddrW-1:0] word);
      logic [memAddrW-1:0] mirrored;
      for (int i = 0; i < memAddrW; i++)
      begin
         mirrored[i] = word[memAddrW-1-i];
      end
      return mirrored;
   endfunction

endpackage

// File: src/addrGen.sv
`timescale 1ns/1ps

module addrGen (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          init,
   input  logic                          run,
   input  vmemPkg::portCfgT              cfg,
   output logic [vmemPkg::memAddrW-1:0]  addr,
   output logic                          memEn,
   output logic                          done
);

   localparam logic [vmemPkg::periodW-1:0]  stepOne = 1;
   localparam logic [vmemPkg::memAddrW-1:0] iterOne = 1;

   vmemPkg::agStateT               state;
   logic [vmemPkg::periodW-1:0]    delayCnt;
   logic [vmemPkg::periodW-1:0]    step;
   logic [vmemPkg::memAddrW-1:0]   iter;
   logic [vmemPkg::memAddrW-1:0]   curAddr;
   logic [vmemPkg::memAddrW-1:0]   iterBase;
   logic                           lastStep;
   logic                           lastIter;

   assign lastStep = step == cfg.period - stepOne;
   assign lastIter = iter == cfg.iterations - iterOne;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state    <= vmemPkg::agIdle;
         delayCnt <= '0;
         step     <= '0;
         iter     <= '0;
         curAddr  <= '0;
         iterBase <= '0;
      end
      else if (init)
      begin
         state    <= vmemPkg::agIdle;
         delayCnt <= '0;
         step     <= '0;
         iter     <= '0;
         curAddr  <= cfg.start;
         iterBase <= cfg.start;
      end
      else
      begin
         case (state)
            vmemPkg::agIdle:
               // an empty program never starts
               if (run && cfg.iterations != '0)
               begin
                  delayCnt <= stepOne;
                  step     <= '0;
                  iter     <= '0;
                  curAddr  <= cfg.start;
                  iterBase <= cfg.start;
                  state    <= (cfg.delay == '0) ? vmemPkg::agRun : vmemPkg::agDelay;
               end
            vmemPkg::agDelay:
               if (delayCnt == cfg.delay)
                  state <= vmemPkg::agRun;
               else
                  delayCnt <= delayCnt + stepOne;
            vmemPkg::agRun:
               if (lastStep)
               begin
                  // next iteration restarts from the shifted base
                  step     <= '0;
                  iter     <= iter + iterOne;
                  iterBase <= iterBase + cfg.shift;
                  curAddr  <= iterBase + cfg.shift;
                  if (lastIter)
                     state <= vmemPkg::agDone;
               end
               else
               begin
                  step    <= step + stepOne;
                  curAddr <= curAddr + cfg.incr;
               end
            default:
               // done holds until the next init
               state <= vmemPkg::agDone;
         endcase
      end
   end

   assign addr  = cfg.reverse ? vmemPkg::reverseBits(curAddr) : curAddr;
   assign memEn = (state == vmemPkg::agRun) && (step < cfg.duty);
   assign done  = state == vmemPkg::agDone;

   // program stays put while a walk is in progress
   assert property (@(posedge clk) disable iff (!rstN)
      (state == vmemPkg::agDelay || state == vmemPkg::agRun) |-> $stable(cfg));

endmodule

// File: src/inputMux.sv
`timescale 1ns/1ps

module inputMux #(
   parameter int dataW = 32
) (
   input  logic [vmemPkg::selW-1:0]        sel,
   input  logic [vmemPkg::nSrc*dataW-1:0]  flowIn,
   output logic [dataW-1:0]                dataOut
);

   int wordIdx;

   // word 0 lives in the top slice of the bus
   always_comb
   begin
      wordIdx = vmemPkg::nSrc - 1 - int'(sel);
      dataOut = flowIn[wordIdx*dataW +: dataW];
   end

endmodule

// File: src/dualPortRam.sv
`timescale 1ns/1ps

module dualPortRam #(
   parameter int dataW = 32
) (
   input  logic                          clk,
   input  logic                          enA,
   input  logic                          enB,
   input  logic                          weA,
   input  logic                          weB,
   input  logic [vmemPkg::memAddrW-1:0]  addrA,
   input  logic [vmemPkg::memAddrW-1:0]  addrB,
   input  logic [dataW-1:0]              dataA,
   input  logic [dataW-1:0]              dataB,
   output logic [dataW-1:0]              qA,
   output logic [dataW-1:0]              qB
);

   logic [dataW-1:0] mem [2**vmemPkg::memAddrW];

   // read-first on both ports
   always_ff @(posedge clk)
   begin
      if (enA)
      begin
         if (weA)
            mem[addrA] <= dataA;
         qA <= mem[addrA];
      end
      if (enB)
      begin
         if (weB)
            mem[addrB] <= dataB;
         qB <= mem[addrB];
      end
   end

   assert property (@(posedge clk) !(enA && weA && enB && weB && addrA == addrB));

endmodule

// File: src/memUnit.sv
`timescale 1ns/1ps

module memUnit #(
   parameter int dataW = 32
) (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          cfgWe,
   input  logic                          cfgPort,
   input  vmemPkg::portCfgT              cfgData,
   input  logic                          initA,
   input  logic                          initB,
   input  logic                          runA,
   input  logic                          runB,
   output logic                          doneA,
   output logic                          doneB,
   input  logic                          hostValid,
   input  logic                          hostWe,
   input  logic [vmemPkg::memAddrW-1:0]  hostAddr,
   input  logic [dataW-1:0]              hostWdata,
   input  logic [vmemPkg::nSrc*dataW-1:0] flowIn,
   output logic [2*dataW-1:0]            flowOut
);

   vmemPkg::portCfgT              cfgA;
   vmemPkg::portCfgT              cfgB;
   logic [vmemPkg::memAddrW-1:0]  genAddrA;
   logic [vmemPkg::memAddrW-1:0]  genAddrB;
   logic [vmemPkg::memAddrW-1:0]  addrA;
   logic [vmemPkg::memAddrW-1:0]  addrOutA;
   logic [vmemPkg::memAddrW-1:0]  addrOutB;
   logic                          genEnA;
   logic                          genEnB;
   logic                          enA;
   logic                          weA;
   logic                          weB;
   logic                          liveA;
   logic                          liveB;
   logic [dataW-1:0]              muxA;
   logic [dataW-1:0]              muxB;
   logic [dataW-1:0]              dataA;
   logic [dataW-1:0]              qA;
   logic [dataW-1:0]              qB;
   logic [dataW-1:0]              outA;
   logic [dataW-1:0]              outB;

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         cfgA <= '0;
         cfgB <= '0;
      end
      else if (cfgWe)
      begin
         if (cfgPort)
            cfgB <= cfgData;
         else
            cfgA <= cfgData;
      end
   end

   addrGen uGenA (.clk, .rstN, .init(initA), .run(runA), .cfg(cfgA),
                  .addr(genAddrA), .memEn(genEnA), .done(doneA));
   addrGen uGenB (.clk, .rstN, .init(initB), .run(runB), .cfg(cfgB),
                  .addr(genAddrB), .memEn(genEnB), .done(doneB));

   inputMux #(.dataW(dataW)) uMuxA (.sel(cfgA.sel), .flowIn, .dataOut(muxA));
   inputMux #(.dataW(dataW)) uMuxB (.sel(cfgB.sel), .flowIn, .dataOut(muxB));

   // host takes over port A
   assign enA   = hostValid | genEnA;
   assign addrA = hostValid ? hostAddr : genAddrA;
   assign dataA = hostValid ? hostWdata : muxA;
   assign weA   = hostValid ? hostWe : (genEnA & cfgA.writeEn);
   assign weB   = genEnB & cfgB.writeEn;

   dualPortRam #(.dataW(dataW)) uRam (
      .clk,
      .enA,
      .enB(genEnB),
      .weA,
      .weB,
      .addrA,
      .addrB(genAddrB),
      .dataA,
      .dataB(muxB),
      .qA,
      .qB
   );

   // address path, same latency as a read
   always_ff @(posedge clk)
   begin
      if (enA)
         addrOutA <= addrA;
      if (genEnB)
         addrOutB <= genAddrB;
   end

   // outputs stay zero until the port first fires
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         liveA <= 1'b0;
         liveB <= 1'b0;
      end
      else
      begin
         liveA <= liveA | enA;
         liveB <= liveB | genEnB;
      end
   end

   assign outA = !liveA ? '0 :
                 cfgA.addrOutEn ? {{(dataW-vmemPkg::memAddrW){addrOutA[vmemPkg::memAddrW-1]}},
                                   addrOutA} : qA;
   assign outB = !liveB ? '0 :
                 cfgB.addrOutEn ? {{(dataW-vmemPkg::memAddrW){addrOutB[vmemPkg::memAddrW-1]}},
                                   addrOutB} : qB;

   assign flowOut = {outA, outB};

   // host must stay off port A while its generator drives it
   assert property (@(posedge clk) disable iff (!rstN) hostValid |-> !genEnA);

endmodule

// File: src/vmemCluster.sv
`timescale 1ns/1ps

module vmemCluster #(
   parameter int dataW = 32
) (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           cfgWe,
   input  logic                           cfgUnit,
   input  logic                           cfgPort,
   input  vmemPkg::portCfgT               cfgData,
   input  logic [1:0]                     initA,
   input  logic [1:0]                     initB,
   input  logic [1:0]                     runA,
   input  logic [1:0]                     runB,
   output logic [1:0]                     doneA,
   output logic [1:0]                     doneB,
   input  logic                           hostValid,
   input  logic                           hostWe,
   input  logic                           hostUnit,
   input  logic [vmemPkg::memAddrW-1:0]   hostAddr,
   input  logic [dataW-1:0]               hostWdata,
   output logic [dataW-1:0]               hostRdata,
   output logic [vmemPkg::nSrc*dataW-1:0] flowBus
);

   logic [2*dataW-1:0] unitOut [2];
   logic               hostUnitQ;

   // unit 0 in the top half, so word 0 is unit 0 port A
   assign flowBus = {unitOut[0], unitOut[1]};

   for (genvar u = 0; u < 2; u++)
   begin : gUnit
      memUnit #(.dataW(dataW)) uMem (
         .clk,
         .rstN,
         .cfgWe(cfgWe && cfgUnit == 1'(u)),
         .cfgPort,
         .cfgData,
         .initA(initA[u]),
         .initB(initB[u]),
         .runA(runA[u]),
         .runB(runB[u]),
         .doneA(doneA[u]),
         .doneB(doneB[u]),
         .hostValid(hostValid && hostUnit == 1'(u)),
         .hostWe,
         .hostAddr,
         .hostWdata,
         .flowIn(flowBus),
         .flowOut(unitOut[u])
      );
   end

   // read data is one cycle behind the request
   always_ff @(posedge clk)
   begin
      if (!rstN)
         hostUnitQ <= 1'b0;
      else if (hostValid)
         hostUnitQ <= hostUnit;
   end

   assign hostRdata = hostUnitQ ? unitOut[1][2*dataW-1 -: dataW] : unitOut[0][2*dataW-1 -: dataW];

endmodule

// File: bench/vmemClusterTb.sv
`timescale 1ns/1ps

module vmemClusterTb;

   localparam int dataW = 32;
   localparam int aw = vmemPkg::memAddrW;
   localparam int pw = vmemPkg::periodW;
   localparam int maxCases = 64;

   logic                           clk;
   logic                           rstN;
   logic                           cfgWe;
   logic                           cfgUnit;
   logic                           cfgPort;
   vmemPkg::portCfgT               cfgData;
   logic [1:0]                     initA;
   logic [1:0]                     initB;
   logic [1:0]                     runA;
   logic [1:0]                     runB;
   logic [1:0]                     doneA;
   logic [1:0]                     doneB;
   logic                           hostValid;
   logic                           hostWe;
   logic                           hostUnit;
   logic [aw-1:0]                  hostAddr;
   logic [dataW-1:0]               hostWdata;
   logic [dataW-1:0]               hostRdata;
   logic [vmemPkg::nSrc*dataW-1:0] flowBus;

   int               seed = 32'hec7d;
   int               cycleCount = 0;
   int               cycleLimit = 0;
   int               nCases = 0;
   string            caseName [maxCases];
   string            caseKind [maxCases];
   // iter period srcDuty delay srcStart srcShift srcIncr dstDuty dstStart dstShift dstIncr rev done
   int               field [maxCases][13];
   logic [dataW-1:0] ref0 [256];
   logic [dataW-1:0] ref1 [256];

   vmemCluster #(.dataW(dataW)) i_vmemCluster (
      .clk, .rstN,
      .cfgWe, .cfgUnit, .cfgPort, .cfgData,
      .initA, .initB, .runA, .runB, .doneA, .doneB,
      .hostValid, .hostWe, .hostUnit, .hostAddr, .hostWdata, .hostRdata,
      .flowBus
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abortRun(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   always @(posedge clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit)
         abortRun("simulation timed out");
   end

   task automatic checkWord(input string name, input logic [dataW-1:0] expected,
                            input logic [dataW-1:0] actual);
      if (actual !== expected)
         abortRun($sformatf("ERR %s: expected %h, got %h", name, expected, actual));
   endtask

   task automatic checkAddr(input string name, input logic [aw-1:0] expected,
                            input logic [aw-1:0] actual);
      if (actual !== expected)
         abortRun($sformatf("ERR %s: expected address %h, got %h", name, expected, actual));
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
         abortRun($sformatf("ERR %s: expected done %b, got %b", name, expected, actual));
   endtask

   // start + i*shift + j*incr modulo 256, mirrored when reverse is set
   function automatic logic [aw-1:0] walkAddr(input int c, input int base, input int s);
      logic [aw-1:0] raw;
      logic [aw-1:0] mirrored;
      raw = aw'(field[c][base] + (s / field[c][1]) * field[c][base + 1]
                + (s % field[c][1]) * field[c][base + 2]);
      for (int b = 0; b < aw; b++)
         mirrored[aw-1-b] = raw[b];
      return (field[c][11] != 0) ? mirrored : raw;
   endfunction

   function automatic vmemPkg::portCfgT makeCfg(input int c, input int duty, input int delay,
                                                input int base, input logic we, input logic aoe);
      vmemPkg::portCfgT p;
      p            = '0;
      p.iterations = aw'(field[c][0]);
      p.period     = pw'(field[c][1]);
      p.duty       = pw'(duty);
      p.delay      = pw'(delay);
      p.start      = aw'(field[c][base]);
      p.shift      = aw'(field[c][base + 1]);
      p.incr       = aw'(field[c][base + 2]);
      p.reverse    = field[c][11] != 0;
      p.writeEn    = we;
      p.addrOutEn  = aoe;
      return p;
   endfunction

   task automatic setCfg(input logic unit, input logic port, input vmemPkg::portCfgT cfg);
      cfgWe   = 1'b1;
      cfgUnit = unit;
      cfgPort = port;
      cfgData = cfg;
      @(negedge clk);
      cfgWe = 1'b0;
   endtask

   task automatic hostAccess(input logic unit, input logic we, input logic [aw-1:0] addr,
                             input logic [dataW-1:0] wdata, output logic [dataW-1:0] rdata);
      hostValid = 1'b1;
      hostWe    = we;
      hostUnit  = unit;
      hostAddr  = addr;
      hostWdata = wdata;
      @(negedge clk);
      hostValid = 1'b0;
      hostWe    = 1'b0;
      rdata     = hostRdata;
   endtask

   // init drops every done on the next edge
   task automatic pulseInit(input int c);
      initA = 2'b11;
      initB = 2'b11;
      @(negedge clk);
      initA = 2'b00;
      initB = 2'b00;
      checkFlag(caseName[c], 1'b0, |{doneA, doneB});
   endtask

   task automatic clearPorts(input int c);
      for (int u = 0; u < 2; u++)
      begin
         setCfg(1'(u), 1'b0, '0);
         setCfg(1'(u), 1'b1, '0);
      end
      pulseInit(c);
   endtask

   task automatic runHost(input int c);
      logic [dataW-1:0] word;
      logic [dataW-1:0] got;
      for (int k = 0; k < field[c][0]; k++)
      begin
         word = dataW'($random(seed));
         ref0[aw'(field[c][4] + k)] = word;
         hostAccess(1'b0, 1'b1, aw'(field[c][4] + k), word, got);
      end
      for (int k = 0; k < field[c][0]; k++)
      begin
         hostAccess(1'b0, 1'b0, aw'(field[c][4] + k), '0, got);
         checkWord(caseName[c], ref0[aw'(field[c][4] + k)], got);
      end
   endtask

   task automatic runCopy(input int c);
      int               n;
      logic [dataW-1:0] word;
      logic [dataW-1:0] got;
      logic [dataW-1:0] srcOut;
      n = field[c][0] * field[c][1];
      setCfg(1'b0, 1'b0, makeCfg(c, field[c][2], field[c][3], 4, 1'b0, 1'b0));
      // destination waits one cycle longer to catch the source's read data
      setCfg(1'b1, 1'b1, makeCfg(c, field[c][7], field[c][3] + 1, 8, 1'b1, 1'b0));
      for (int s = 0; s < n; s++)
      begin
         word = dataW'($random(seed));
         ref0[walkAddr(c, 4, s)] = word;
         hostAccess(1'b0, 1'b1, walkAddr(c, 4, s), word, got);
         word = dataW'($random(seed));
         ref1[walkAddr(c, 8, s)] = word;
         hostAccess(1'b1, 1'b1, walkAddr(c, 8, s), word, got);
      end
      // flow word 0 holds its last read through skipped source steps
      srcOut = '0;
      for (int s = 0; s < n; s++)
      begin
         if (s % field[c][1] < field[c][2])
            srcOut = ref0[walkAddr(c, 4, s)];
         if (s % field[c][1] < field[c][7])
            ref1[walkAddr(c, 8, s)] = srcOut;
      end
      runA = 2'b01;
      runB = 2'b10;
      for (int k = 1; k <= field[c][12] + 3; k++)
      begin
         @(negedge clk);
         runA = 2'b00;
         runB = 2'b00;
         checkFlag(caseName[c], k >= field[c][12] - 1, doneA[0]);
         checkFlag(caseName[c], k >= field[c][12], doneB[1]);
      end
      pulseInit(c);
      for (int s = 0; s < n; s++)
      begin
         hostAccess(1'b1, 1'b0, walkAddr(c, 8, s), '0, got);
         checkWord(caseName[c], ref1[walkAddr(c, 8, s)], got);
      end
   endtask

   task automatic runAddrOut(input int c);
      int               s;
      logic [aw-1:0]    last;
      logic [dataW-1:0] word;
      setCfg(1'b1, 1'b0, makeCfg(c, field[c][2], field[c][3], 4, 1'b0, 1'b1));
      // unit 1 port B stays at zero iterations
      runA = 2'b10;
      runB = 2'b10;
      last = '0;
      for (int k = 1; k <= field[c][12] + 3; k++)
      begin
         @(negedge clk);
         runA = 2'b00;
         runB = 2'b00;
         checkFlag(caseName[c], k >= field[c][12], doneA[1]);
         checkFlag(caseName[c], 1'b0, doneB[1]);
         // address shows one cycle after its access
         s = k - field[c][3] - 2;
         if (s >= 0 && s < field[c][0] * field[c][1] && s % field[c][1] < field[c][2])
            last = walkAddr(c, 4, s);
         if (s >= 0)
         begin
            word = flowBus[dataW +: dataW];
            checkAddr(caseName[c], last, word[aw-1:0]);
            checkWord(caseName[c], {{(dataW - aw){last[aw-1]}}, last}, word);
         end
      end
      pulseInit(c);
   endtask

   initial
   begin
      int    fd;
      int    code;
      string line;
      rstN      = 1'b0;
      cfgWe     = 1'b0;
      cfgUnit   = 1'b0;
      cfgPort   = 1'b0;
      cfgData   = '0;
      initA     = 2'b00;
      initB     = 2'b00;
      runA      = 2'b00;
      runB      = 2'b00;
      hostValid = 1'b0;
      hostWe    = 1'b0;
      hostUnit  = 1'b0;
      hostAddr  = '0;
      hostWdata = '0;
      fd = $fopen("bench/memCases.txt", "r");
      if (fd == 0)
         abortRun("cannot open bench/memCases.txt");
      while (!$feof(fd))
      begin
         code = $fgets(line, fd);
         if (code == 0 || line.len() < 2 || line[0] == "#")
            continue;
         if (nCases == maxCases)
            abortRun("too many cases in bench/memCases.txt");
         code = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d %d %d %d %d",
                        caseName[nCases], caseKind[nCases], field[nCases][0],
                        field[nCases][1], field[nCases][2], field[nCases][3],
                        field[nCases][4], field[nCases][5], field[nCases][6],
                        field[nCases][7], field[nCases][8], field[nCases][9],
                        field[nCases][10], field[nCases][11], field[nCases][12]);
         if (code != 15)
            abortRun("malformed line in bench/memCases.txt");
         cycleLimit += field[nCases][3] + field[nCases][0] * field[nCases][1] + 300;
         nCases++;
      end
      $fclose(fd);
      repeat (4) @(negedge clk);
      rstN = 1'b1;
      for (int w = 0; w < vmemPkg::nSrc; w++)
         checkWord("reset", '0, flowBus[w*dataW +: dataW]);
      checkWord("reset", '0, hostRdata);
      checkFlag("reset", 1'b0, |{doneA, doneB});
      for (int c = 0; c < nCases; c++)
      begin
         clearPorts(c);
         if (caseKind[c] == "host")
            runHost(c);
         else if (caseKind[c] == "copy")
            runCopy(c);
         else if (caseKind[c] == "addr")
            runAddrOut(c);
         else
            abortRun($sformatf("unknown case kind %s", caseKind[c]));
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: bench/memCases.txt
# name kind iter period srcDuty delay srcStart srcShift srcIncr dstDuty dstStart dstShift dstIncr rev done
# host: iter words from srcStart; copy: unit 0 A to unit 1 B, done is the destination's; addr: unit 1 A
host_low host 16 1 1 0 0 0 0 0 0 0 0 0 0
host_wrap host 12 1 1 0 250 0 0 0 0 0 0 0 0
copy_flat copy 1 8 8 0 32 0 1 8 96 0 1 0 10
copy_loop copy 2 4 4 1 16 8 1 4 100 8 1 0 11
copy_stride copy 3 5 5 2 40 20 3 5 130 10 2 0 19
copy_wrap copy 4 3 3 0 250 3 2 3 240 7 5 0 14
copy_overlap copy 3 4 4 3 70 1 1 4 20 1 1 0 17
copy_late copy 2 2 2 29 4 2 1 2 9 2 1 0 35
duty_half copy 4 4 4 1 60 4 1 2 180 4 1 0 19
duty_one copy 3 6 6 3 0 7 2 1 200 11 3 0 23
duty_none copy 2 3 3 0 10 3 1 0 50 3 1 0 8
duty_src copy 2 5 3 2 90 9 1 5 150 9 1 0 14
rev_full addr 3 4 4 2 5 16 1 0 0 0 0 1 15
rev_gap addr 2 5 3 0 130 64 7 0 0 0 0 1 11
addr_plain addr 4 2 2 4 200 3 9 0 0 0 0 0 13
rev_delay addr 2 3 3 30 1 2 33 0 0 0 0 1 37

// File: flist.f
src/vmemPkg.sv
src/addrGen.sv
src/inputMux.sv
src/dualPortRam.sv
src/memUnit.sv
src/vmemCluster.sv
bench/vmemClusterTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module vmemClusterTb --Mdir obj_dir -o vmemSim

./obj_dir/vmemSim | tee sim.log

if grep -qx "TESTS PASSED" sim.log
then
   exit 0
fi
exit 1
